/* spi_bridge_pkg.sv */
`default_nettype none

package spi_bridge_pkg;

  localparam int WORD_BITS = 16;                   // memory word width

  // region byte, top eight bits of the host address
  localparam logic [7:0] REGION_MEM  = 8'h00;      // word memory
  localparam logic [7:0] REGION_CTRL = 8'hFF;      // 8-bit control register

  // first byte of every host transaction
  localparam logic [7:0] CMD_WRITE = 8'h00;
  localparam logic [7:0] CMD_READ  = 8'h01;

  // memory view: region, word index, byte within word
  typedef struct packed {
    logic [7:0]  region;
    logic [22:0] index;                            // 16-bit word index
    logic        bsel;                             // 0 = high byte, 1 = low byte
  } mem_view_t;

  // control view: region and a don't-care offset
  typedef struct packed {
    logic [7:0]  region;
    logic [23:0] offset;                           // not decoded
  } ctrl_view_t;

  typedef union packed {
    mem_view_t  mem;
    ctrl_view_t ctrl;
  } spi_addr_t;

endpackage

`default_nettype wire

/* spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave
(
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       csn,
  input  wire                       sclk,
  input  wire                       mosi,
  output logic                      miso,
  input  wire  [7:0]                byte_in,     // next read byte from the packer
  output logic [7:0]                byte_out,    // last received data byte
  output spi_bridge_pkg::spi_addr_t addr,
  output logic                      wr_byte,
  output logic                      rd_byte
);

  localparam logic [2:0] ST_CMD  = 3'd0;         // waiting for command byte
  localparam logic [2:0] ST_ADDR = 3'd1;         // four address bytes msb first
  localparam logic [2:0] ST_WR   = 3'd2;         // write data bytes
  localparam logic [2:0] ST_RD   = 3'd3;         // read data bytes
  localparam logic [2:0] ST_SKIP = 3'd4;         // unknown command idles until csn

  logic [1:0]  csn_sync;
  logic [2:0]  sclk_sync;                        // third flop for edge detect
  logic [1:0]  mosi_sync;
  logic        cs_active;
  logic        sclk_rise;
  logic        sclk_fall;
  logic [2:0]  state;
  logic [2:0]  bit_cnt;                          // rises within current byte
  logic [1:0]  addr_cnt;                         // address bytes received
  logic        read_mode;
  logic [7:0]  shift_in;
  logic [7:0]  rx_byte;
  logic        byte_done;
  logic [7:0]  shift_out;
  logic [31:0] addr_q;

  // two-flop synchronizers on the pins
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      csn_sync  <= 2'b11;                        // deselected
      sclk_sync <= 3'b000;                       // mode 0 idle low
      mosi_sync <= 2'b00;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], csn};
      sclk_sync <= {sclk_sync[1:0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign cs_active = ~csn_sync[1];
  assign sclk_rise = cs_active & sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = cs_active & ~sclk_sync[1] & sclk_sync[2];
  assign rx_byte   = {shift_in[6:0], mosi_sync[1]};  // byte incl. bit on this rise
  assign byte_done = sclk_rise & (bit_cnt == 3'd7);

  // mosi sampled msb first on rising sclk
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_in <= rx_byte;
    if (byte_done && state == ST_WR)
      byte_out <= rx_byte;                       // held through wr_byte
  end

  // command / address / data FSM
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= ST_CMD;
      bit_cnt   <= 3'd0;
      addr_cnt  <= 2'd0;
      read_mode <= 1'b0;
      addr_q    <= 32'd0;
      wr_byte   <= 1'b0;
      rd_byte   <= 1'b0;
    end
    else if (!cs_active)
    begin
      state    <= ST_CMD;                        // csn high aborts
      bit_cnt  <= 3'd0;
      addr_cnt <= 2'd0;
      wr_byte  <= 1'b0;
      rd_byte  <= 1'b0;
    end
    else
    begin
      wr_byte <= 1'b0;
      rd_byte <= 1'b0;
      if (wr_byte)
        addr_q <= addr_q + 32'd1;                // advance after the write strobe
      if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1;               // wraps every byte
      if (byte_done)
      begin
        case (state)
          ST_CMD:
          begin
            addr_cnt <= 2'd0;
            if (rx_byte == spi_bridge_pkg::CMD_READ)
            begin
              read_mode <= 1'b1;
              state     <= ST_ADDR;
            end
            else if (rx_byte == spi_bridge_pkg::CMD_WRITE)
            begin
              read_mode <= 1'b0;
              state     <= ST_ADDR;
            end
            else
              state <= ST_SKIP;
          end
          ST_ADDR:
          begin
            addr_q   <= {addr_q[23:0], rx_byte};
            addr_cnt <= addr_cnt + 2'd1;
            if (addr_cnt == 2'd3)
            begin
              state   <= read_mode ? ST_RD : ST_WR;
              rd_byte <= read_mode;              // prefetch first read byte
            end
          end
          ST_WR:
            wr_byte <= 1'b1;
          ST_RD:
          begin
            addr_q  <= addr_q + 32'd1;           // byte just went out
            rd_byte <= 1'b1;                     // fetch the next one
          end
          default:
            state <= state;
        endcase
      end
    end
  end

  // miso shifts on falling sclk; new byte loads on the first fall of a byte
  always_ff @(posedge clk)
  begin
    if (!rst_n || !cs_active)
      shift_out <= 8'h00;
    else if (sclk_fall && state == ST_RD)
      shift_out <= (bit_cnt == 3'd0) ? byte_in : {shift_out[6:0], 1'b0};
  end

  assign miso = shift_out[7];
  assign addr = addr_q;

  a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_byte && read_mode) && !(rd_byte && !read_mode));  // strobes follow the command

endmodule

`default_nettype wire

/* word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_packer
#(
  parameter int DEPTH_BITS = 8
)
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire spi_bridge_pkg::spi_addr_t         addr,
  input  wire                                    wr_byte,
  input  wire                                    rd_byte,
  input  wire  [7:0]                             byte_out,
  output logic [7:0]                             byte_in,
  output logic                                   mem_wr,
  output logic                                   mem_rd,
  output logic [DEPTH_BITS-1:0]                  mem_index,
  output logic [spi_bridge_pkg::WORD_BITS-1:0]   mem_wdata,
  input  wire  [spi_bridge_pkg::WORD_BITS-1:0]   mem_rdata,
  output logic [7:0]                             ctrl
);

  localparam int WB = spi_bridge_pkg::WORD_BITS;

  logic                  in_mem;
  logic                  in_ctrl;
  logic                  odd_wr;                 // low byte of a memory word
  logic [7:0]            stage_hi;
  logic [7:0]            stage_lo;
  logic [DEPTH_BITS-1:0] wr_index;               // index of the pending word
  logic [DEPTH_BITS-1:0] rd_index;

  // one address word read through both views
  assign in_mem   = (addr.mem.region == spi_bridge_pkg::REGION_MEM);
  assign in_ctrl  = (addr.ctrl.region == spi_bridge_pkg::REGION_CTRL);
  assign odd_wr   = wr_byte & in_mem & addr.mem.bsel;
  assign rd_index = addr.mem.index[DEPTH_BITS-1:0];

  // big-endian two-byte staging
  always_ff @(posedge clk)
  begin
    if (wr_byte && in_mem)
    begin
      if (addr.mem.bsel)
        stage_lo <= byte_out;
      else
        stage_hi <= byte_out;
    end
    if (odd_wr)
      wr_index <= rd_index;                      // addr moves on before mem_wr
  end

  assign mem_wdata = {stage_hi, stage_lo};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mem_wr <= 1'b0;
      ctrl   <= 8'h00;
    end
    else
    begin
      mem_wr <= odd_wr;                          // only a completed pair is stored
      if (wr_byte && in_ctrl)
        ctrl <= byte_out;
    end
  end

  assign mem_rd    = rd_byte & in_mem;           // same cycle as the request
  assign mem_index = mem_wr ? wr_index : rd_index;

  // read byte select with other regions reading zero
  always_comb
  begin
    if (in_mem)
      byte_in = addr.mem.bsel ? mem_rdata[7:0] : mem_rdata[WB-1 -: 8];
    else if (in_ctrl)
      byte_in = ctrl;
    else
      byte_in = 8'h00;
  end

  a_pair_write: assert property (@(posedge clk) disable iff (!rst_n)
    odd_wr |=> mem_wr && (mem_index == $past(rd_index))
               && (mem_wdata[7:0] == $past(byte_out)));  // odd byte closes the word

endmodule

`default_nettype wire

/* word_store.sv */
`timescale 1ns/1ps
`default_nettype none

module word_store
#(
  parameter int DEPTH_BITS = 8
)
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire                                    mem_wr,
  input  wire                                    mem_rd,
  input  wire  [DEPTH_BITS-1:0]                  mem_index,
  input  wire  [spi_bridge_pkg::WORD_BITS-1:0]   mem_wdata,
  output logic [spi_bridge_pkg::WORD_BITS-1:0]   mem_rdata
);

  localparam int WB    = spi_bridge_pkg::WORD_BITS;
  localparam int WORDS = 1 << DEPTH_BITS;

  logic [WB-1:0] words [0:WORDS-1];
  logic [WB-1:0] rd_stage;                       // first read stage
  logic          rd_pend;                        // read in flight

  // write port and two-stage read path
  always_ff @(posedge clk)
  begin
    if (mem_wr)
      words[mem_index] <= mem_wdata;
    if (mem_rd)
      rd_stage <= words[mem_index];
    if (rd_pend)
      mem_rdata <= rd_stage;                     // held until next read
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rd_pend <= 1'b0;
    else
      rd_pend <= mem_rd;
  end

  // packer keeps reads and writes in separate cycles
  a_no_rw: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_wr && mem_rd));

endmodule

`default_nettype wire

/* spi_ram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_ram_bridge
#(
  parameter int DEPTH_BITS = 8                   // implemented word-index bits
)
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       csn,
  input  wire       sclk,
  input  wire       mosi,
  output wire       miso,
  output wire [7:0] ctrl
);

  spi_bridge_pkg::spi_addr_t                addr;
  wire                                      wr_byte;
  wire                                      rd_byte;
  wire [7:0]                                byte_out;   // host to fabric
  wire [7:0]                                byte_in;    // fabric to host
  wire                                      mem_wr;
  wire                                      mem_rd;
  wire [DEPTH_BITS-1:0]                     mem_index;
  wire [spi_bridge_pkg::WORD_BITS-1:0]      mem_wdata;
  wire [spi_bridge_pkg::WORD_BITS-1:0]      mem_rdata;

  spi_slave spi_slave_i
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .csn      (csn),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .byte_in  (byte_in),
    .byte_out (byte_out),
    .addr     (addr),
    .wr_byte  (wr_byte),
    .rd_byte  (rd_byte)
  );

  word_packer #(.DEPTH_BITS(DEPTH_BITS)) word_packer_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .wr_byte   (wr_byte),
    .rd_byte   (rd_byte),
    .byte_out  (byte_out),
    .byte_in   (byte_in),
    .mem_wr    (mem_wr),
    .mem_rd    (mem_rd),
    .mem_index (mem_index),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .ctrl      (ctrl)
  );

  word_store #(.DEPTH_BITS(DEPTH_BITS)) word_store_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_wr    (mem_wr),
    .mem_rd    (mem_rd),
    .mem_index (mem_index),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* tb_spi_tasks.svh */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
  #(DRIVE_SKEW);                                 // land just after the edge
endtask

// one mode 0 sclk cycle
task automatic shift_bit(input logic b, output logic s);
  mosi = b;
  wait_clks(SCLK_HALF);
  s    = miso;                                   // sampled just before the rise
  sclk = 1'b1;
  wait_clks(SCLK_HALF);
  sclk = 1'b0;                                   // slave shifts miso here
endtask

task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
  logic s;
  for (int i = 7; i >= 0; i--)
  begin
    shift_bit(tx[i], s);                         // msb first
    rx[i] = s;
  end
endtask

task automatic send_header(input logic [7:0] cmd, input spi_bridge_pkg::spi_addr_t a);
  logic [31:0] raw;
  logic [7:0]  dummy;
  raw = a;
  shift_byte(cmd, dummy);
  for (int i = 3; i >= 0; i--)
    shift_byte(raw[8*i +: 8], dummy);            // address msb first
endtask

task automatic spi_write_burst(input logic [7:0] cmd, input spi_bridge_pkg::spi_addr_t a,
                               input logic [7:0] data [$]);
  logic [7:0] dummy;
  csn = 1'b0;
  wait_clks(SCLK_HALF);                          // cs setup
  send_header(cmd, a);
  foreach (data[i])
    shift_byte(data[i], dummy);
  wait_clks(SCLK_HALF);
  csn = 1'b1;
  wait_clks(4 * SCLK_HALF);                      // idle gap between transactions
endtask

task automatic spi_read_burst(input spi_bridge_pkg::spi_addr_t a, input int n,
                              output logic [7:0] data [$]);
  logic [7:0] b;
  data = {};
  csn  = 1'b0;
  wait_clks(SCLK_HALF);
  send_header(spi_bridge_pkg::CMD_READ, a);
  repeat (n)
  begin
    shift_byte(8'h00, b);                        // mosi idle during data phase
    data.push_back(b);
  end
  wait_clks(SCLK_HALF);
  csn = 1'b1;
  wait_clks(4 * SCLK_HALF);
endtask

`endif

/* tb_spi_ram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_ram_bridge;

  localparam int          CLK_PERIOD    = 40;
  localparam int          DRIVE_SKEW    = 2;       // ns after rising edge
  localparam int          RESET_CLKS    = 10;
  localparam int          SCLK_HALF     = 4;       // clk per sclk half period
  localparam logic [15:0] LFSR_SEED     = 16'd91;
  localparam int          TEST_COUNT    = 6;
  localparam int          WATCHDOG_CLKS = TEST_COUNT * 3 * 40 * 80 + RESET_CLKS;
  localparam logic [31:0] BURST_BYTES   = 32'h1234_5678;  // first byte on top

  logic        clk = 1'b0;
  logic        rst_n;
  logic        csn;
  logic        sclk;
  logic        mosi;
  wire         miso;
  wire  [7:0]  ctrl;
  string       test_name;
  int          test_fails   = 0;
  int          check_count  = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [15:0] lfsr_state;

  spi_ram_bridge #(.DEPTH_BITS(8)) dut_i
  (
    .clk   (clk),
    .rst_n (rst_n),
    .csn   (csn),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .ctrl  (ctrl)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "tb_spi_tasks.svh"

  function automatic spi_bridge_pkg::spi_addr_t mem_addr(input logic [7:0] region,
                                                         input logic [23:0] byte_ofs);
    spi_bridge_pkg::spi_addr_t a;
    a.mem.region = region;
    a.mem.index  = byte_ofs[23:1];               // word index
    a.mem.bsel   = byte_ofs[0];                  // 0 = high byte
    return a;
  endfunction

  function automatic spi_bridge_pkg::spi_addr_t ctrl_addr(input logic [23:0] offset);
    spi_bridge_pkg::spi_addr_t a;
    a.ctrl.region = spi_bridge_pkg::REGION_CTRL;
    a.ctrl.offset = offset;                      // ignored by the bridge
    return a;
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);        // one step per bit
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("FAIL %s %s expected 0x%02h actual 0x%02h", test_name, what, exp, got);
      test_fails++;
    end
  endtask

  task automatic read_expect(input spi_bridge_pkg::spi_addr_t a, input logic [7:0] exp [$]);
    logic [7:0] got [$];
    spi_read_burst(a, exp.size(), got);
    foreach (exp[i])
      check_byte($sformatf("byte %0d", i), exp[i], got[i]);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_fails = 0;
  endtask

  task automatic finish_test();
    if (test_fails == 0)
    begin
      tests_passed++;
      $display("test %s done, no mismatches", test_name);
    end
    else
    begin
      tests_failed++;
      $display("test %s done, %0d mismatches", test_name, test_fails);
    end
  endtask

  task automatic test_reset_state();
    logic [7:0] exp [$];
    start_test("reset_state");
    check_byte("ctrl", 8'h00, ctrl);
    exp.push_back(8'h00);
    read_expect(ctrl_addr(24'h0), exp);          // control register cleared
    finish_test();
  endtask

  task automatic test_burst_rw();
    logic [7:0] data [$];
    start_test("burst_rw");
    for (int i = 3; i >= 0; i--)
      data.push_back(BURST_BYTES[8*i +: 8]);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h00, 24'h10), data);
    read_expect(mem_addr(8'h00, 24'h10), data);  // two big-endian words
    finish_test();
  endtask

  task automatic test_lone_byte();
    logic [7:0] word_q [$];
    logic [7:0] lone_q [$];
    start_test("lone_byte");
    word_q.push_back(8'hA5);
    word_q.push_back(8'h5A);
    lone_q.push_back(8'h11);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h00, 24'h20), word_q);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h00, 24'h20), lone_q);
    read_expect(mem_addr(8'h00, 24'h20), word_q);  // even byte alone never stored
    finish_test();
  endtask

  task automatic test_ctrl_reg();
    logic [7:0] mem_q [$];
    logic [7:0] reg_q [$];
    start_test("ctrl_reg");
    mem_q.push_back(8'hC0);
    mem_q.push_back(8'hDE);
    reg_q.push_back(8'h3C);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h00, 24'h0), mem_q);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, ctrl_addr(24'h1), reg_q);  // low byte of word 0
    check_byte("ctrl", 8'h3C, ctrl);
    read_expect(ctrl_addr(24'h0), reg_q);
    read_expect(mem_addr(8'h00, 24'h0), mem_q);  // word 0 untouched
    finish_test();
  endtask

  task automatic test_unmapped();
    logic [7:0] zero_q [$];
    logic [7:0] junk_q [$];
    logic [7:0] old_q [$];
    start_test("unmapped");
    zero_q.push_back(8'h00);
    zero_q.push_back(8'h00);
    junk_q.push_back(8'hEE);
    junk_q.push_back(8'hEF);
    for (int i = 3; i >= 0; i--)
      old_q.push_back(BURST_BYTES[8*i +: 8]);
    read_expect(mem_addr(8'h42, 24'h10), zero_q);
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h42, 24'h10), junk_q);
    check_byte("ctrl", 8'h3C, ctrl);
    read_expect(mem_addr(8'h00, 24'h10), old_q);  // same index bits in another region
    finish_test();
  endtask

  task automatic test_random_burst();
    logic [7:0] data [$];
    logic [7:0] lo_q [$];
    logic [7:0] hi_q [$];
    logic [7:0] b;
    start_test("random_burst");
    for (int i = 0; i < 32; i++)
    begin
      rand_byte(b);
      data.push_back(b);
      if (i < 16)
        lo_q.push_back(b);
      else
        hi_q.push_back(b);
    end
    spi_write_burst(spi_bridge_pkg::CMD_WRITE, mem_addr(8'h00, 24'h40), data);
    read_expect(mem_addr(8'h00, 24'h40), lo_q);
    read_expect(mem_addr(8'h00, 24'h50), hi_q);  // second half in its own transaction
    finish_test();
  endtask

  initial
  begin
    rst_n      = 1'b0;
    csn        = 1'b1;                           // deselected
    sclk       = 1'b0;                           // mode 0 idle
    mosi       = 1'b0;
    lfsr_state = LFSR_SEED;
    wait_clks(RESET_CLKS);
    rst_n = 1'b1;
    wait_clks(4);
    test_reset_state();
    test_burst_rw();
    test_lone_byte();
    test_ctrl_reg();
    test_unmapped();
    test_random_burst();
    $display("summary: %0d tests, %0d passed, %0d failed, %0d checks",
             TEST_COUNT, tests_passed, tests_failed, check_count);
    if (tests_failed == 0 && tests_passed == TEST_COUNT)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // bound from worst-case transaction length
  initial
  begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CLKS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
spi_bridge_pkg.sv
spi_slave.sv
word_packer.sv
word_store.sv
spi_ram_bridge.sv
tb_spi_ram_bridge.sv

/* Makefile */
TOP = tb_spi_ram_bridge

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
